/* Makefile */
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module a2_card_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Va2_card_tb

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+hdl
hdl/a2_card_pkg.sv
hdl/shared_mem.sv
hdl/bus_shadow.sv
hdl/video_fetch.sv
hdl/sample_fetch.sv
hdl/audio_mix.sv
hdl/a2_card_top.sv
dv/a2_card_properties.sv
dv/a2_card_tb.sv

/* dv/a2_card_properties.sv */
`timescale 1ns/1ps

module a2_card_properties (
    input logic                   clk_logic_w,
    input logic                   arst_n_i,
    input a2_card_pkg::port_vec_t req_i,
    input a2_card_pkg::port_vec_t gnt_i,
    input logic                   video_rd_i,
    input logic                   video_valid_i
);

    a2_card_pkg::port_vec_t above_w;  // Ports that outrank the granted one

    assign above_w = gnt_i - 1'b1;

    grant_onehot_a: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        $onehot0(gnt_i))
        else $error("more than one memory port granted");

    // Grant only where a request stands
    grant_to_req_a: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        (gnt_i & ~req_i) == '0)
        else $error("grant to a port without a request");

    grant_priority_a: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        (|gnt_i) |-> ((above_w & req_i) == '0))
        else $error("grant skipped a higher priority request");

    // Video answer is exactly two cycles behind the read pulse
    video_latency_a: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        video_valid_i == $past(video_rd_i, 2))
        else $error("video_valid_o not two cycles after video_rd_i");

endmodule

/* dv/a2_card_tb.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module a2_card_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_SEED    = 75461;
    localparam int BUS_GAP      = 9;    // Cycles taken by one drive_bus call
    localparam int N_LOW        = 64;
    localparam int N_IO         = 8;
    localparam int N_SAMPLES    = 4 * `A2_WAVE_WORDS;  // Two passes over the table
    localparam int N_MIX_READS  = 400;
    localparam int N_MIX_WRITES = 80;
    localparam int WAVE_BYTES   = 4 * `A2_WAVE_WORDS;
    localparam int WAVE_ADDR    = 4 * `A2_WAVE_BASE;   // Byte address of the table
    localparam int SAMPLE_WAIT  = 2 * `A2_SAMPLE_DIV;
    localparam int PLAY_CYCLES  = (N_SAMPLES + 2) * `A2_SAMPLE_DIV;
    localparam int TEST_CYCLES  = RESET_CYCLES + 20
                                + N_LOW * BUS_GAP + 2 * (N_LOW + 1)
                                + N_IO * BUS_GAP + 4 * (N_IO + 1) + 2 * (N_LOW + 1)
                                + 2 * (WAVE_BYTES + 3) * BUS_GAP + 3 * PLAY_CYCLES;
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    logic                  clk_logic_w;
    logic                  arst_n_i;
    logic                  bus_strobe_i;
    a2_card_pkg::a2_addr_t bus_addr_i;
    a2_card_pkg::a2_byte_t bus_data_i;
    logic                  bus_rw_n_i;
    logic                  video_rd_i;
    a2_card_pkg::a2_addr_t video_addr_i;
    a2_card_pkg::a2_byte_t video_data_o;
    logic                  video_valid_o;
    logic                  sound_en_i;
    a2_card_pkg::sample_t  audio_o;
    logic                  audio_valid_o;

    // Reference model, Apple byte space plus the speaker
    a2_card_pkg::a2_byte_t mem_model [0:65535];
    bit                    known [0:65535];
    bit                    spk_model;
    a2_card_pkg::a2_addr_t low_q[$];
    a2_card_pkg::a2_addr_t read_q[$];
    int                    cycle_cnt = 0;

    a2_card_top dut_i (.*);

    bind a2_card_top a2_card_properties props_i (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .req_i         (req_w),
        .gnt_i         (gnt_w),
        .video_rd_i    (video_rd_i),
        .video_valid_i (video_valid_o)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input a2_card_pkg::a2_byte_t got,
                              input a2_card_pkg::a2_byte_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sample(input string name, input a2_card_pkg::sample_t got,
                                input a2_card_pkg::sample_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_logic_w);
        #(DRIVE_DLY);
    endtask

    function automatic a2_card_pkg::a2_byte_t rand_byte();
        return a2_card_pkg::a2_byte_t'($urandom);
    endfunction

    // One bus cycle, then idle so strobes stay 8 or more cycles apart
    task automatic drive_bus(input a2_card_pkg::a2_addr_t addr,
                             input a2_card_pkg::a2_byte_t data, input logic rw_n);
        next_cycle();
        bus_strobe_i = 1'b1;
        bus_addr_i   = addr;
        bus_data_i   = data;
        bus_rw_n_i   = rw_n;
        if (!rw_n && addr < `A2_IO_PAGE) begin
            mem_model[addr] = data;
            known[addr]     = 1'b1;
        end
        if (addr == `A2_SPEAKER_ADDR) begin
            spk_model = !spk_model;  // Reads toggle too
        end
        next_cycle();
        bus_strobe_i = 1'b0;
        repeat (BUS_GAP - 2) next_cycle();
    endtask

    task automatic write_sample(input int idx, input logic [15:0] value);
        drive_bus(a2_card_pkg::a2_addr_t'(WAVE_ADDR + 2 * idx), value[7:0], 1'b0);
        drive_bus(a2_card_pkg::a2_addr_t'(WAVE_ADDR + 2 * idx + 1), value[15:8], 1'b0);
    endtask

    function automatic a2_card_pkg::sample_t model_sample(input int idx);
        a2_card_pkg::a2_addr_t lo;
        lo = a2_card_pkg::a2_addr_t'(WAVE_ADDR + 2 * idx);  // Low half of each word first
        return a2_card_pkg::sample_t'({mem_model[lo + 16'd1], mem_model[lo]});
    endfunction

    function automatic a2_card_pkg::sample_t mixed_sample(input int idx);
        int sum;
        sum = int'(model_sample(idx));
        if (spk_model) begin
            sum = sum + int'(`A2_SPEAKER_LEVEL);
        end
        if (sum > 32767) begin
            return 16'sh7FFF;
        end else if (sum < -32768) begin
            return 16'sh8000;
        end
        return a2_card_pkg::sample_t'(sum);
    endfunction

    // Reads from read_q every second cycle, answer due two cycles later
    task automatic run_video_reads();
        int                    n;
        a2_card_pkg::a2_addr_t addr;
        n = read_q.size();
        for (int i = 0; i <= n; i++) begin
            next_cycle();
            check_flag("video_valid_o", video_valid_o, i > 0);
            if (i > 0) begin
                addr = read_q[i-1];
                if (known[addr]) begin
                    check_byte($sformatf("video_data_o @%h", addr), video_data_o,
                               mem_model[addr]);
                end else begin
                    mem_model[addr] = video_data_o;  // Power-up content, never shadowed
                    known[addr]     = 1'b1;
                end
            end
            if (i < n) begin
                video_rd_i   = 1'b1;
                video_addr_i = read_q[i];
            end
            next_cycle();
            video_rd_i = 1'b0;
            check_flag("video_valid_o", video_valid_o, 1'b0);
        end
    endtask

    task automatic wait_audio();
        int waited;
        waited = 0;
        next_cycle();
        while (audio_valid_o !== 1'b1) begin
            waited++;
            if (waited > SAMPLE_WAIT) begin
                $display("No audio_valid_o pulse within %0d cycles", SAMPLE_WAIT);
                stop_on_error();
            end
            next_cycle();
        end
    endtask

    // Restart sound from the table base and check N_SAMPLES outputs
    task automatic play_samples(input bit toggle_spk);
        int last;
        last = 0;
        next_cycle();
        sound_en_i = 1'b0;
        next_cycle();
        sound_en_i = 1'b1;
        for (int idx = 0; idx < N_SAMPLES; idx++) begin
            wait_audio();
            if (idx > 0 && cycle_cnt - last != `A2_SAMPLE_DIV) begin
                $display("Audio sample %0d came %0d cycles after the one before",
                         idx, cycle_cnt - last);
                stop_on_error();
            end
            last = cycle_cnt;
            check_sample("audio_o", audio_o, mixed_sample(idx % (2 * `A2_WAVE_WORDS)));
            if (toggle_spk && $urandom_range(1, 0) == 1) begin
                drive_bus(`A2_SPEAKER_ADDR, rand_byte(), 1'($urandom_range(1, 0)));
            end
        end
    endtask

    task automatic shadow_traffic();
        repeat (N_MIX_WRITES) begin
            drive_bus(a2_card_pkg::a2_addr_t'($urandom_range(16'h2FFF, 16'h2000)),
                      rand_byte(), 1'($urandom_range(1, 0)));
        end
    endtask

    initial begin
        a2_card_pkg::a2_addr_t addr;
        logic [15:0]           value;
        void'($urandom(RAND_SEED));
        arst_n_i     = 1'b0;
        bus_strobe_i = 1'b0;
        bus_addr_i   = '0;
        bus_data_i   = '0;
        bus_rw_n_i   = 1'b1;
        video_rd_i   = 1'b0;
        video_addr_i = '0;
        sound_en_i   = 1'b0;
        spk_model    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        #(DRIVE_DLY);
        arst_n_i = 1'b1;

        // Quiet card after reset
        repeat (20) begin
            next_cycle();
            check_flag("video_valid_o", video_valid_o, 1'b0);
            check_flag("audio_valid_o", audio_valid_o, 1'b0);
            check_sample("audio_o", audio_o, '0);
        end

        // Shadow writes into 16 words, so lanes share words
        repeat (N_LOW) begin
            addr = a2_card_pkg::a2_addr_t'($urandom_range(63, 0));
            low_q.push_back(addr);
            drive_bus(addr, rand_byte(), 1'b0);
        end
        read_q.delete();
        repeat (N_LOW) begin
            read_q.push_back(low_q[$urandom_range(N_LOW - 1, 0)]);
        end
        run_video_reads();

        // I/O page writes must not reach memory
        read_q.delete();
        repeat (N_IO) begin
            do begin
                addr = a2_card_pkg::a2_addr_t'($urandom_range(16'hFFFF, 16'hC000));
            end while (addr == `A2_SPEAKER_ADDR);
            read_q.push_back(addr);
        end
        run_video_reads();
        foreach (read_q[i]) begin
            drive_bus(read_q[i], rand_byte(), 1'b0);
        end
        run_video_reads();
        read_q = low_q;
        run_video_reads();

        // Wavetable playback, speaker off
        for (int b = 0; b < WAVE_BYTES; b++) begin
            drive_bus(a2_card_pkg::a2_addr_t'(WAVE_ADDR + b), rand_byte(), 1'b0);
        end
        play_samples(1'b0);
        next_cycle();
        sound_en_i = 1'b0;

        // Near both limits, speaker toggled on and during playback
        for (int k = 0; k < 2 * `A2_WAVE_WORDS; k++) begin
            case (k % 3)
                0:       value = 16'h7000 | 16'($urandom_range(16'h0FFF, 0));
                1:       value = 16'h8000 | 16'($urandom_range(16'h0FFF, 0));
                default: value = 16'($urandom);
            endcase
            write_sample(k, value);
        end
        drive_bus(`A2_SPEAKER_ADDR, rand_byte(), 1'b1);
        play_samples(1'b1);
        next_cycle();
        sound_en_i = 1'b0;

        // Video, shadow and sound all busy together
        read_q.delete();
        repeat (N_MIX_READS) begin
            if ($urandom_range(1, 0) == 1) begin
                read_q.push_back(low_q[$urandom_range(N_LOW - 1, 0)]);
            end else begin
                read_q.push_back(a2_card_pkg::a2_addr_t'(WAVE_ADDR +
                                 $urandom_range(WAVE_BYTES - 1, 0)));
            end
        end
        fork
            play_samples(1'b0);
            run_video_reads();
            shadow_traffic();
        join
        next_cycle();
        sound_en_i = 1'b0;

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* hdl/a2_card_pkg.sv */
`include "a2_card_settings.svh"

package a2_card_pkg;

    // Apple side
    typedef logic [15:0] a2_addr_t;
    typedef logic [7:0]  a2_byte_t;

    // Card memory word address
    typedef logic [`A2_MEM_AW-1:0] mem_addr_t;

    typedef logic signed [15:0] sample_t;

    // One memory word, seen as bytes by video and shadow,
    // as a pair of samples by the wavetable reader
    typedef union packed {
        a2_byte_t [3:0] bytes;    // Lane 0 is the low byte
        sample_t  [1:0] samples;  // Index 0 in the low half
    } mem_word_u;

    // One bit per memory port
    typedef logic [`A2_NUM_PORTS-1:0] port_vec_t;

endpackage

/* hdl/a2_card_settings.svh */
`ifndef A2_CARD_SETTINGS_SVH
`define A2_CARD_SETTINGS_SVH

// Memory geometry, 16K words of 32 bits
`define A2_MEM_AW        14
`define A2_NUM_PORTS     3

// Port numbers, lowest wins arbitration
`define A2_PORT_VIDEO    0
`define A2_PORT_SHADOW   1
`define A2_PORT_SAMPLE   2

`define A2_IO_PAGE       16'hC000  // First byte address not shadowed
`define A2_SPEAKER_ADDR  16'hC030
`define A2_SPEAKER_LEVEL 16'h1000

`define A2_WAVE_BASE     'h1000    // Word address of the wavetable
`define A2_WAVE_WORDS    8         // Two samples per word
`define A2_SAMPLE_DIV    64        // Clocks per sample

`endif

/* hdl/a2_card_top.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module a2_card_top (
    input  logic                  clk_logic_w,
    input  logic                  arst_n_i,
    input  logic                  bus_strobe_i,
    input  a2_card_pkg::a2_addr_t bus_addr_i,
    input  a2_card_pkg::a2_byte_t bus_data_i,
    input  logic                  bus_rw_n_i,
    input  logic                  video_rd_i,
    input  a2_card_pkg::a2_addr_t video_addr_i,
    output a2_card_pkg::a2_byte_t video_data_o,
    output logic                  video_valid_o,
    input  logic                  sound_en_i,
    output a2_card_pkg::sample_t  audio_o,
    output logic                  audio_valid_o
);

    a2_card_pkg::port_vec_t                     req_w;
    a2_card_pkg::port_vec_t                     gnt_w;
    a2_card_pkg::port_vec_t                     we_w;
    a2_card_pkg::port_vec_t                     rvalid_w;
    a2_card_pkg::mem_addr_t [`A2_NUM_PORTS-1:0] addr_w;
    a2_card_pkg::mem_word_u [`A2_NUM_PORTS-1:0] wdata_w;
    logic [`A2_NUM_PORTS-1:0][3:0]              be_w;
    a2_card_pkg::mem_word_u                     rdata_w;
    a2_card_pkg::sample_t                       sample_w;
    logic                                       sample_valid_w;

    // Only the shadow port writes
    assign we_w                     = a2_card_pkg::port_vec_t'(1 << `A2_PORT_SHADOW);
    assign wdata_w[`A2_PORT_VIDEO]  = '0;
    assign be_w[`A2_PORT_VIDEO]     = '0;
    assign wdata_w[`A2_PORT_SAMPLE] = '0;
    assign be_w[`A2_PORT_SAMPLE]    = '0;

    shared_mem mem_i (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .req_i       (req_w),
        .addr_i      (addr_w),
        .we_i        (we_w),
        .wdata_i     (wdata_w),
        .be_i        (be_w),
        .gnt_o       (gnt_w),
        .rdata_o     (rdata_w),
        .rvalid_o    (rvalid_w)
    );

    bus_shadow shadow_i (
        .clk_logic_w  (clk_logic_w),
        .arst_n_i     (arst_n_i),
        .bus_strobe_i (bus_strobe_i),
        .bus_addr_i   (bus_addr_i),
        .bus_data_i   (bus_data_i),
        .bus_rw_n_i   (bus_rw_n_i),
        .gnt_i        (gnt_w[`A2_PORT_SHADOW]),
        .req_o        (req_w[`A2_PORT_SHADOW]),
        .addr_o       (addr_w[`A2_PORT_SHADOW]),
        .wdata_o      (wdata_w[`A2_PORT_SHADOW]),
        .be_o         (be_w[`A2_PORT_SHADOW])
    );

    video_fetch video_i (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .video_rd_i    (video_rd_i),
        .video_addr_i  (video_addr_i),
        .rdata_i       (rdata_w),
        .rvalid_i      (rvalid_w[`A2_PORT_VIDEO]),
        .req_o         (req_w[`A2_PORT_VIDEO]),
        .addr_o        (addr_w[`A2_PORT_VIDEO]),
        .video_data_o  (video_data_o),
        .video_valid_o (video_valid_o)
    );

    sample_fetch sample_i (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (arst_n_i),
        .sound_en_i     (sound_en_i),
        .gnt_i          (gnt_w[`A2_PORT_SAMPLE]),
        .rdata_i        (rdata_w),
        .rvalid_i       (rvalid_w[`A2_PORT_SAMPLE]),
        .req_o          (req_w[`A2_PORT_SAMPLE]),
        .addr_o         (addr_w[`A2_PORT_SAMPLE]),
        .sample_o       (sample_w),
        .sample_valid_o (sample_valid_w)
    );

    audio_mix mix_i (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (arst_n_i),
        .bus_strobe_i   (bus_strobe_i),
        .bus_addr_i     (bus_addr_i),
        .sample_i       (sample_w),
        .sample_valid_i (sample_valid_w),
        .audio_o        (audio_o),
        .audio_valid_o  (audio_valid_o)
    );

endmodule

/* hdl/audio_mix.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module audio_mix (
    input  logic                  clk_logic_w,
    input  logic                  arst_n_i,
    input  logic                  bus_strobe_i,
    input  a2_card_pkg::a2_addr_t bus_addr_i,
    input  a2_card_pkg::sample_t  sample_i,
    input  logic                  sample_valid_i,
    output a2_card_pkg::sample_t  audio_o,
    output logic                  audio_valid_o
);

    localparam logic signed [16:0] SUM_MAX = 17'sd32767;
    localparam logic signed [16:0] SUM_MIN = -17'sd32768;

    logic                 spk_q;
    a2_card_pkg::sample_t audio_q;
    logic                 valid_q;
    logic signed [16:0]   level_w;
    logic signed [16:0]   sum_w;
    a2_card_pkg::sample_t clip_w;

    assign level_w = spk_q ? 17'(`A2_SPEAKER_LEVEL) : 17'sd0;
    assign sum_w   = 17'(sample_i) + level_w;  // One guard bit

    always_comb begin
        if (sum_w > SUM_MAX) begin
            clip_w = 16'sh7FFF;
        end else if (sum_w < SUM_MIN) begin
            clip_w = 16'sh8000;
        end else begin
            clip_w = sum_w[15:0];
        end
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spk_q   <= 1'b0;
            audio_q <= '0;
            valid_q <= 1'b0;
        end else begin
            // Any access to the speaker soft switch flips the cone
            if (bus_strobe_i && bus_addr_i == `A2_SPEAKER_ADDR) begin
                spk_q <= ~spk_q;
            end
            valid_q <= sample_valid_i;
            if (sample_valid_i) begin
                audio_q <= clip_w;
            end
        end
    end

    assign audio_o       = audio_q;
    assign audio_valid_o = valid_q;

endmodule

/* hdl/bus_shadow.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module bus_shadow (
    input  logic                   clk_logic_w,
    input  logic                   arst_n_i,
    input  logic                   bus_strobe_i,
    input  a2_card_pkg::a2_addr_t  bus_addr_i,
    input  a2_card_pkg::a2_byte_t  bus_data_i,
    input  logic                   bus_rw_n_i,
    input  logic                   gnt_i,
    output logic                   req_o,
    output a2_card_pkg::mem_addr_t addr_o,
    output a2_card_pkg::mem_word_u wdata_o,
    output logic [3:0]             be_o
);

    logic                   capture_w;
    a2_card_pkg::mem_word_u lane_word_w;

    logic                   req_q;
    a2_card_pkg::mem_addr_t addr_q;
    a2_card_pkg::mem_word_u wdata_q;
    logic [3:0]             be_q;

    // Only CPU writes below the I/O page are copied
    assign capture_w = bus_strobe_i && !bus_rw_n_i && (bus_addr_i < `A2_IO_PAGE);

    // Byte moved into its lane, the rest stays zero
    always_comb begin
        lane_word_w                       = '0;
        lane_word_w.bytes[bus_addr_i[1:0]] = bus_data_i;
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
        end else if (capture_w) begin
            req_q <= 1'b1;
        end else if (gnt_i) begin
            req_q <= 1'b0;  // Write done this cycle
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (capture_w) begin
            addr_q  <= bus_addr_i[15:2];
            wdata_q <= lane_word_w;
            be_q    <= 4'b0001 << bus_addr_i[1:0];
        end
    end

    assign req_o   = req_q;
    assign addr_o  = addr_q;
    assign wdata_o = wdata_q;
    assign be_o    = be_q;

endmodule

/* hdl/sample_fetch.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module sample_fetch (
    input  logic                   clk_logic_w,
    input  logic                   arst_n_i,
    input  logic                   sound_en_i,
    input  logic                   gnt_i,
    input  a2_card_pkg::mem_word_u rdata_i,
    input  logic                   rvalid_i,
    output logic                   req_o,
    output a2_card_pkg::mem_addr_t addr_o,
    output a2_card_pkg::sample_t   sample_o,
    output logic                   sample_valid_o
);

    localparam int DIV_W = $clog2(`A2_SAMPLE_DIV);
    localparam int PTR_W = $clog2(`A2_WAVE_WORDS);

    logic [DIV_W-1:0]       div_q;
    logic [PTR_W-1:0]       ptr_q;
    logic                   req_q;
    logic                   busy_q;     // Request out or read in flight
    logic                   buf_valid_q;
    logic                   half_q;     // 0 low sample next, 1 high
    logic                   sample_valid_q;
    a2_card_pkg::mem_word_u buf_q;
    a2_card_pkg::sample_t   sample_q;
    logic                   tick_w;

    assign tick_w = sound_en_i && (div_q == DIV_W'(`A2_SAMPLE_DIV - 1));

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q          <= '0;
            ptr_q          <= '0;
            req_q          <= 1'b0;
            busy_q         <= 1'b0;
            buf_valid_q    <= 1'b0;
            half_q         <= 1'b0;
            sample_valid_q <= 1'b0;
        end else if (!sound_en_i) begin
            // Stopped, next start reads from the table base again
            div_q          <= '0;
            ptr_q          <= '0;
            req_q          <= 1'b0;
            busy_q         <= 1'b0;
            buf_valid_q    <= 1'b0;
            half_q         <= 1'b0;
            sample_valid_q <= 1'b0;
        end else begin
            sample_valid_q <= 1'b0;
            div_q          <= tick_w ? '0 : div_q + 1'b1;

            if (!buf_valid_q && !busy_q) begin
                req_q  <= 1'b1;
                busy_q <= 1'b1;
            end else if (gnt_i) begin
                req_q <= 1'b0;
            end

            if (rvalid_i && busy_q) begin
                buf_valid_q <= 1'b1;
                busy_q      <= 1'b0;
            end

            if (tick_w && buf_valid_q) begin
                sample_valid_q <= 1'b1;
                half_q         <= ~half_q;
                if (half_q) begin
                    // Word used up, move on and refetch
                    buf_valid_q <= 1'b0;
                    ptr_q <= (ptr_q == PTR_W'(`A2_WAVE_WORDS - 1)) ? '0 : ptr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rvalid_i && busy_q) begin
            buf_q <= rdata_i;
        end
        if (tick_w && buf_valid_q) begin
            sample_q <= buf_q.samples[half_q];
        end
    end

    assign req_o          = req_q;
    assign addr_o         = a2_card_pkg::mem_addr_t'(`A2_WAVE_BASE) +
                            a2_card_pkg::mem_addr_t'(ptr_q);
    assign sample_o       = sample_q;
    assign sample_valid_o = sample_valid_q;

endmodule

/* hdl/shared_mem.sv */
`timescale 1ns/1ps
`include "a2_card_settings.svh"

module shared_mem (
    input  logic                                            clk_logic_w,
    input  logic                                            arst_n_i,
    input  a2_card_pkg::port_vec_t                          req_i,
    input  a2_card_pkg::mem_addr_t [`A2_NUM_PORTS-1:0]      addr_i,
    input  a2_card_pkg::port_vec_t                          we_i,
    input  a2_card_pkg::mem_word_u [`A2_NUM_PORTS-1:0]      wdata_i,
    input  logic [`A2_NUM_PORTS-1:0][3:0]                   be_i,
    output a2_card_pkg::port_vec_t                          gnt_o,
    output a2_card_pkg::mem_word_u                          rdata_o,
    output a2_card_pkg::port_vec_t                          rvalid_o
);

    localparam int SEL_W = $clog2(`A2_NUM_PORTS);

    a2_card_pkg::mem_word_u mem_q [0:(1 << `A2_MEM_AW)-1];

    a2_card_pkg::port_vec_t gnt_w;
    logic [SEL_W-1:0]       sel_w;
    logic                   any_w;
    a2_card_pkg::mem_word_u rdata_q;
    a2_card_pkg::port_vec_t rvalid_q;

    // Fixed priority, walk down so the lowest requester is the last written
    always_comb begin
        gnt_w = '0;
        sel_w = '0;
        for (int p = `A2_NUM_PORTS - 1; p >= 0; p--) begin
            if (req_i[p]) begin
                gnt_w    = '0;
                gnt_w[p] = 1'b1;
                sel_w    = SEL_W'(p);
            end
        end
    end

    assign any_w = |req_i;

    always_ff @(posedge clk_logic_w) begin
        if (any_w && we_i[sel_w]) begin
            for (int l = 0; l < 4; l++) begin
                if (be_i[sel_w][l]) begin
                    mem_q[addr_i[sel_w]].bytes[l] <= wdata_i[sel_w].bytes[l];
                end
            end
        end
        if (any_w && !we_i[sel_w]) begin
            rdata_q <= mem_q[addr_i[sel_w]];
        end
    end

    // Read data tagged one cycle after the grant
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= '0;
        end else begin
            rvalid_q <= gnt_w & ~we_i;
        end
    end

    assign gnt_o    = gnt_w;
    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

endmodule

/* hdl/video_fetch.sv */
`timescale 1ns/1ps

module video_fetch (
    input  logic                   clk_logic_w,
    input  logic                   arst_n_i,
    input  logic                   video_rd_i,
    input  a2_card_pkg::a2_addr_t  video_addr_i,
    input  a2_card_pkg::mem_word_u rdata_i,
    input  logic                   rvalid_i,
    output logic                   req_o,
    output a2_card_pkg::mem_addr_t addr_o,
    output a2_card_pkg::a2_byte_t  video_data_o,
    output logic                   video_valid_o
);

    logic [1:0]            lane_q;
    a2_card_pkg::a2_byte_t data_q;
    logic                  valid_q;

    // Top priority port, the grant comes in the same cycle
    assign req_o  = video_rd_i;
    assign addr_o = video_addr_i[15:2];

    // Lane follows the read into the data cycle
    always_ff @(posedge clk_logic_w) begin
        if (video_rd_i) begin
            lane_q <= video_addr_i[1:0];
        end
        if (rvalid_i) begin
            data_q <= rdata_i.bytes[lane_q];
        end
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rvalid_i;
        end
    end

    assign video_data_o  = data_q;
    assign video_valid_o = valid_q;

endmodule
